/* hdl/bomber_pkg.sv */
//--------------------------------------
// Bomber arena shared definitions
// Arena constants, key codes and game types
//--------------------------------------
package bomber_pkg;

    //--------------------------------------
    // Vector types
    //--------------------------------------
    typedef logic [9:0]  coord_t;      // Screen coordinate
    typedef logic [31:0] key_report_t; // Four 8-bit key slots
    typedef logic [7:0]  key_code_t;   // USB key code

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    //--------------------------------------
    // Enums
    //--------------------------------------
    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_UP,
        CMD_DOWN,
        CMD_LEFT,
        CMD_RIGHT,
        CMD_BOMB
    } player_cmd_e;

    typedef enum logic [1:0] {
        BOMB_IDLE,
        BOMB_ARMED,
        BOMB_EXPLODING
    } bomb_state_e;

    typedef enum logic {
        ROUND_PLAY,
        ROUND_OVER
    } round_state_e;

    typedef enum logic {
        TUNE_MAIN,
        TUNE_DEFEAT
    } tune_e;

    typedef struct packed {
        bomb_state_e state;
        pos_t        centre;
    } bomb_status_t;

    //--------------------------------------
    // Arena geometry and timing
    //--------------------------------------
    localparam coord_t TILE        = 10'd20;
    localparam coord_t ARENA_MIN   = 10'd20;
    localparam coord_t ARENA_MAX_X = 10'd620;
    localparam coord_t ARENA_MAX_Y = 10'd460;
    localparam int     BLAST_REACH  = 4;  // In tiles
    localparam int     FUSE_FRAMES  = 8;
    localparam int     BLAST_FRAMES = 4;
    localparam int     FRAME_CNT_W  = 4;

    localparam pos_t P1_START = '{x: 10'd40,  y: 10'd40};
    localparam pos_t P2_START = '{x: 10'd600, y: 10'd440};

    // Player 1 keys
    localparam key_code_t KEY_W     = 8'h1A;
    localparam key_code_t KEY_A     = 8'h04;
    localparam key_code_t KEY_D     = 8'h07;
    localparam key_code_t KEY_S     = 8'h16;
    localparam key_code_t KEY_SPACE = 8'h2C;

    // Player 2 keys
    localparam key_code_t KEY_UP    = 8'h52;
    localparam key_code_t KEY_LEFT  = 8'h50;
    localparam key_code_t KEY_RIGHT = 8'h4F;
    localparam key_code_t KEY_DOWN  = 8'h51;
    localparam key_code_t KEY_ENTER = 8'h28;

endpackage

/* hdl/key_decoder.sv */
//--------------------------------------
// Keyboard report decoder
// One command per player plus LED pattern
//--------------------------------------
`timescale 1ns/100ps

module key_decoder (
    input  bomber_pkg::key_report_t key_report,
    output bomber_pkg::player_cmd_e p1_cmd,
    output bomber_pkg::player_cmd_e p2_cmd,
    output logic [3:0]              led
);
    import bomber_pkg::*;

    // True if the code sits in any slot of the report
    function automatic logic key_seen(input key_report_t report, input key_code_t code);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < $bits(key_report_t) / $bits(key_code_t); i++)
        begin
            if (report[i*8 +: 8] == code)
                seen = 1'b1;
        end
        return seen;
    endfunction

    // Later matches win, bomb has the last word
    function automatic player_cmd_e resolve(
        input key_report_t report,
        input key_code_t   up,
        input key_code_t   left,
        input key_code_t   right,
        input key_code_t   down,
        input key_code_t   bomb
    );
        player_cmd_e cmd;
        cmd = CMD_NONE;
        if (key_seen(report, up))
            cmd = CMD_UP;
        if (key_seen(report, left))
            cmd = CMD_LEFT;
        if (key_seen(report, right))
            cmd = CMD_RIGHT;
        if (key_seen(report, down))
            cmd = CMD_DOWN;
        if (key_seen(report, bomb))
            cmd = CMD_BOMB;
        return cmd;
    endfunction

    always_comb
    begin
        p1_cmd = resolve(key_report, KEY_W, KEY_A, KEY_D, KEY_S, KEY_SPACE);
        p2_cmd = resolve(key_report, KEY_UP, KEY_LEFT, KEY_RIGHT, KEY_DOWN, KEY_ENTER);
    end

    //--------------------------------------
    // Status LEDs from player 1 direction
    //--------------------------------------
    always_comb
    begin
        led = 4'b0000;
        case (p1_cmd)
            CMD_LEFT:  led = 4'b0001;
            CMD_RIGHT: led = 4'b0010;
            CMD_UP:    led = 4'b0100;
            CMD_DOWN:  led = 4'b1000;
            default:   led = 4'b0000; // Idle or bomb
        endcase
    end

endmodule

/* hdl/player_motion.sv */
//--------------------------------------
// Player position register
// One tile per frame tick, kept inside arena
//--------------------------------------
`timescale 1ns/100ps

module player_motion (
    input  logic                    Clk,
    input  logic                    rst_n,
    input  logic                    frame_tick,
    input  logic                    freeze,
    input  bomber_pkg::player_cmd_e cmd,
    input  bomber_pkg::pos_t        start_pos,
    output bomber_pkg::pos_t        pos
);
    import bomber_pkg::*;

    pos_t pos_q;
    pos_t next_pos;

    //--------------------------------------
    // Bounded step
    //--------------------------------------
    always_comb
    begin
        next_pos = pos_q;
        case (cmd)
            CMD_UP:
            begin
                if (pos_q.y >= ARENA_MIN + TILE)
                    next_pos.y = pos_q.y - TILE;
            end
            CMD_DOWN:
            begin
                if (pos_q.y <= ARENA_MAX_Y - TILE)
                    next_pos.y = pos_q.y + TILE;
            end
            CMD_LEFT:
            begin
                if (pos_q.x >= ARENA_MIN + TILE)
                    next_pos.x = pos_q.x - TILE;
            end
            CMD_RIGHT:
            begin
                if (pos_q.x <= ARENA_MAX_X - TILE)
                    next_pos.x = pos_q.x + TILE;
            end
            default:
            begin
                next_pos = pos_q; // No move, bomb handled elsewhere
            end
        endcase
    end

    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
            pos_q <= start_pos;
        else if (frame_tick && !freeze)
            pos_q <= next_pos;
    end

    assign pos = pos_q;

endmodule

/* hdl/bomb_timer.sv */
//--------------------------------------
// Bomb fuse and blast timer
// One bomb per player, centre latched on drop
//--------------------------------------
`timescale 1ns/100ps

module bomb_timer (
    input  logic                     Clk,
    input  logic                     rst_n,
    input  logic                     frame_tick,
    input  logic                     freeze,
    input  bomber_pkg::player_cmd_e  cmd,
    input  bomber_pkg::pos_t         player_pos,
    output bomber_pkg::bomb_status_t bomb
);
    import bomber_pkg::*;

    localparam logic [FRAME_CNT_W-1:0] FUSE_LAST  = FRAME_CNT_W'(FUSE_FRAMES - 1);
    localparam logic [FRAME_CNT_W-1:0] BLAST_LAST = FRAME_CNT_W'(BLAST_FRAMES - 1);

    bomb_state_e            state_q;
    logic [FRAME_CNT_W-1:0] frame_cnt_q;
    pos_t                   centre_q;

    //--------------------------------------
    // Bomb FSM
    //--------------------------------------
    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q     <= BOMB_IDLE;
            frame_cnt_q <= '0;
            centre_q    <= '0;
        end
        else
        begin
            case (state_q)
                BOMB_IDLE:
                begin
                    // Drop does not wait for a frame tick
                    if (cmd == CMD_BOMB && !freeze)
                    begin
                        state_q     <= BOMB_ARMED;
                        centre_q    <= player_pos;
                        frame_cnt_q <= '0;
                    end
                end
                BOMB_ARMED:
                begin
                    if (frame_tick)
                    begin
                        if (frame_cnt_q == FUSE_LAST)
                        begin
                            state_q     <= BOMB_EXPLODING;
                            frame_cnt_q <= '0;
                        end
                        else
                            frame_cnt_q <= frame_cnt_q + 1'b1;
                    end
                end
                BOMB_EXPLODING:
                begin
                    if (frame_tick)
                    begin
                        if (frame_cnt_q == BLAST_LAST)
                        begin
                            state_q     <= BOMB_IDLE;
                            frame_cnt_q <= '0;
                        end
                        else
                            frame_cnt_q <= frame_cnt_q + 1'b1;
                    end
                end
                default:
                begin
                    state_q     <= BOMB_IDLE;
                    frame_cnt_q <= '0;
                end
            endcase
        end
    end

    assign bomb.state  = state_q;
    assign bomb.centre = centre_q;

endmodule

/* hdl/blast_checker.sv */
//--------------------------------------
// Cross-shaped blast reach test
// Both bombs against both players
//--------------------------------------
`timescale 1ns/100ps

module blast_checker (
    input  bomber_pkg::bomb_status_t p1_bomb,
    input  bomber_pkg::bomb_status_t p2_bomb,
    input  bomber_pkg::pos_t         p1_pos,
    input  bomber_pkg::pos_t         p2_pos,
    output logic [1:0]               hit
);
    import bomber_pkg::*;

    localparam coord_t REACH = coord_t'(BLAST_REACH * TILE); // Arm length in pixels

    function automatic coord_t abs_diff(input coord_t a, input coord_t b);
        return (a >= b) ? a - b : b - a;
    endfunction

    // Inside either arm of the cross, bounds inclusive
    function automatic logic in_blast(input bomb_status_t b, input pos_t p);
        coord_t dx;
        coord_t dy;
        logic   vert_arm;
        logic   horiz_arm;
        dx        = abs_diff(b.centre.x, p.x);
        dy        = abs_diff(b.centre.y, p.y);
        vert_arm  = (dx <= TILE) && (dy <= REACH);
        horiz_arm = (dy <= TILE) && (dx <= REACH);
        return (b.state == BOMB_EXPLODING) && (vert_arm || horiz_arm);
    endfunction

    // Own bomb counts as well
    always_comb
    begin
        hit[0] = in_blast(p1_bomb, p1_pos) || in_blast(p2_bomb, p1_pos);
        hit[1] = in_blast(p1_bomb, p2_pos) || in_blast(p2_bomb, p2_pos);
    end

endmodule

/* hdl/game_ctrl.sv */
//--------------------------------------
// Round control
// Defeat latches, freeze and tune select
//--------------------------------------
`timescale 1ns/100ps

module game_ctrl (
    input  logic                     Clk,
    input  logic                     rst_n,
    input  logic [1:0]               hit,
    output logic [1:0]               defeated,
    output bomber_pkg::round_state_e round_state,
    output logic                     freeze,
    output bomber_pkg::tune_e        tune
);
    import bomber_pkg::*;

    logic [1:0]   defeated_q;
    round_state_e state_q;

    // Sticky until reset
    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
            defeated_q <= 2'b00;
        else
            defeated_q <= defeated_q | hit;
    end

    //--------------------------------------
    // Round FSM
    //--------------------------------------
    always_ff @(posedge Clk or negedge rst_n)
    begin
        if (!rst_n)
            state_q <= ROUND_PLAY;
        else
        begin
            case (state_q)
                ROUND_PLAY:
                begin
                    if (|hit)
                        state_q <= ROUND_OVER; // Same edge as the defeat bit
                end
                ROUND_OVER:
                begin
                    state_q <= ROUND_OVER;
                end
                default:
                begin
                    state_q <= ROUND_PLAY;
                end
            endcase
        end
    end

    assign defeated    = defeated_q;
    assign round_state = state_q;
    assign freeze      = (state_q == ROUND_OVER);
    assign tune        = (state_q == ROUND_OVER) ? TUNE_DEFEAT : TUNE_MAIN;

endmodule

/* hdl/bomber_top.sv */
//--------------------------------------
// Bomb arena game core
// Two players, two bombs, round control
//--------------------------------------
`timescale 1ns/100ps

module bomber_top (
    input  logic                     Clk,
    input  logic                     rst_n,
    input  logic                     frame_tick,
    input  bomber_pkg::key_report_t  key_report,
    output bomber_pkg::pos_t         p1_pos,
    output bomber_pkg::pos_t         p2_pos,
    output bomber_pkg::bomb_status_t p1_bomb,
    output bomber_pkg::bomb_status_t p2_bomb,
    output logic [1:0]               defeated,
    output bomber_pkg::round_state_e round_state,
    output bomber_pkg::tune_e        tune,
    output logic [3:0]               led
);
    import bomber_pkg::*;

    player_cmd_e p1_cmd;
    player_cmd_e p2_cmd;
    logic [1:0]  hit;
    logic        freeze;

    //--------------------------------------
    // Keyboard
    //--------------------------------------
    key_decoder u_key_decoder (
        .key_report (key_report),
        .p1_cmd     (p1_cmd),
        .p2_cmd     (p2_cmd),
        .led        (led)
    );

    //--------------------------------------
    // Players
    //--------------------------------------
    player_motion u_p1_motion (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .freeze     (freeze),
        .cmd        (p1_cmd),
        .start_pos  (P1_START),
        .pos        (p1_pos)
    );

    player_motion u_p2_motion (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .freeze     (freeze),
        .cmd        (p2_cmd),
        .start_pos  (P2_START),
        .pos        (p2_pos)
    );

    //--------------------------------------
    // Bombs
    //--------------------------------------
    bomb_timer u_p1_bomb (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .freeze     (freeze),
        .cmd        (p1_cmd),
        .player_pos (p1_pos),
        .bomb       (p1_bomb)
    );

    bomb_timer u_p2_bomb (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .freeze     (freeze),
        .cmd        (p2_cmd),
        .player_pos (p2_pos),
        .bomb       (p2_bomb)
    );

    blast_checker u_blast_checker (
        .p1_bomb (p1_bomb),
        .p2_bomb (p2_bomb),
        .p1_pos  (p1_pos),
        .p2_pos  (p2_pos),
        .hit     (hit)
    );

    game_ctrl u_game_ctrl (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .hit         (hit),
        .defeated    (defeated),
        .round_state (round_state),
        .freeze      (freeze),
        .tune        (tune)
    );

endmodule

/* dv/tb_clock_gen.sv */
//--------------------------------------
// Testbench clock source, 20 ns period
//--------------------------------------
`timescale 1ns/100ps

module tb_clock_gen (
    output logic Clk
);

    initial
    begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk; // Half period
    end

endmodule

/* dv/tb_bomber_top.sv */
//--------------------------------------
// Bomb arena core testbench
// Table of key reports and expected state
//--------------------------------------
`timescale 1ns/100ps

module tb_bomber_top;
    import bomber_pkg::*;

    localparam key_code_t    NO_KEY         = 8'h00;
    localparam int           DEFEAT_TIMEOUT = 50;  // Cycles
    localparam bomb_status_t IDLE_BOMB      = '{state: BOMB_IDLE, centre: '0};

    // One row of the stimulus table
    typedef struct packed {
        key_report_t  keys;
        logic [7:0]   ticks;
        pos_t         p1_pos;
        pos_t         p2_pos;
        bomb_status_t p1_bomb;
        round_state_e round_state;
        logic [1:0]   defeated;
        tune_e        tune;
        logic [3:0]   led;
    } step_t;

    logic         Clk;
    logic         rst_n;
    logic         frame_tick;
    key_report_t  key_report;
    pos_t         p1_pos;
    pos_t         p2_pos;
    bomb_status_t p1_bomb;
    bomb_status_t p2_bomb;
    logic [1:0]   defeated;
    round_state_e round_state;
    tune_e        tune;
    logic [3:0]   led;

    step_t steps[$];

    tb_clock_gen u_clock_gen (
        .Clk (Clk)
    );

    bomber_top uut (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .frame_tick  (frame_tick),
        .key_report  (key_report),
        .p1_pos      (p1_pos),
        .p2_pos      (p2_pos),
        .p1_bomb     (p1_bomb),
        .p2_bomb     (p2_bomb),
        .defeated    (defeated),
        .round_state (round_state),
        .tune        (tune),
        .led         (led)
    );

    //--------------------------------------
    // Helpers
    //--------------------------------------
    function automatic key_report_t pack_keys(
        input key_code_t k0,
        input key_code_t k1,
        input key_code_t k2,
        input key_code_t k3
    );
        return {k3, k2, k1, k0}; // Slot 0 in the low byte
    endfunction

    function automatic step_t make_step(
        input key_report_t  keys,
        input int           ticks,
        input int           p1x,
        input int           p1y,
        input int           p2x,
        input int           p2y,
        input bomb_state_e  bstate,
        input int           cx,
        input int           cy,
        input round_state_e rstate,
        input logic [1:0]   def,
        input tune_e        tn,
        input logic [3:0]   leds
    );
        step_t s;
        s.keys                = keys;
        s.ticks               = 8'(ticks);
        s.p1_pos.x            = coord_t'(p1x);
        s.p1_pos.y            = coord_t'(p1y);
        s.p2_pos.x            = coord_t'(p2x);
        s.p2_pos.y            = coord_t'(p2y);
        s.p1_bomb.state       = bstate;
        s.p1_bomb.centre.x    = coord_t'(cx);
        s.p1_bomb.centre.y    = coord_t'(cy);
        s.round_state         = rstate;
        s.defeated            = def;
        s.tune                = tn;
        s.led                 = leds;
        return s;
    endfunction

    task automatic compare_value(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Strobes with a random gap of 2 to 5 idle cycles
    task automatic pulse_frame_ticks(input int count);
        int gap;
        for (int n = 0; n < count; n++)
        begin
            gap = 2 + int'($urandom % 4);
            repeat (gap) @(posedge Clk);
            frame_tick <= 1'b1;
            @(posedge Clk);
            frame_tick <= 1'b0;
        end
    endtask

    task automatic wait_for_defeat(input logic [1:0] target);
        int cycles;
        cycles = 0;
        while (defeated !== target && cycles < DEFEAT_TIMEOUT)
        begin
            @(negedge Clk);
            cycles++;
        end
        if (defeated !== target)
        begin
            $display("Timed out waiting for the defeat latch to reach %b", target);
            $display("TEST FAIL");
            $fatal(1, "Defeat latch never set");
        end
    endtask

    //--------------------------------------
    // Stimulus table
    //--------------------------------------
    task automatic load_steps();
        // Reset values
        steps.push_back(make_step(pack_keys(NO_KEY, NO_KEY, NO_KEY, NO_KEY), 0,
            40, 40, 600, 440, BOMB_IDLE, 0, 0, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0000));
        // Right overrides left
        steps.push_back(make_step(pack_keys(KEY_A, NO_KEY, KEY_D, NO_KEY), 1,
            60, 40, 600, 440, BOMB_IDLE, 0, 0, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0010));
        steps.push_back(make_step(pack_keys(NO_KEY, KEY_W, NO_KEY, NO_KEY), 1,
            60, 20, 600, 440, BOMB_IDLE, 0, 0, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0100));
        steps.push_back(make_step(pack_keys(NO_KEY, NO_KEY, NO_KEY, KEY_S), 1,
            60, 40, 600, 440, BOMB_IDLE, 0, 0, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b1000));
        // Left beats up for player 2 alone
        steps.push_back(make_step(pack_keys(KEY_UP, KEY_LEFT, NO_KEY, NO_KEY), 2,
            60, 40, 560, 440, BOMB_IDLE, 0, 0, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0000));
        // Both players run into the arena edges
        steps.push_back(make_step(pack_keys(KEY_A, KEY_DOWN, NO_KEY, NO_KEY), 5,
            20, 40, 560, 460, BOMB_IDLE, 0, 0, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0001));
        // Player 1 walks just out of reach of the first bomb
        steps.push_back(make_step(pack_keys(KEY_SPACE, NO_KEY, NO_KEY, NO_KEY), 0,
            20, 40, 560, 460, BOMB_ARMED, 20, 40, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0000));
        steps.push_back(make_step(pack_keys(KEY_D, NO_KEY, NO_KEY, NO_KEY), 4,
            100, 40, 560, 460, BOMB_ARMED, 20, 40, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0010));
        steps.push_back(make_step(pack_keys(KEY_D, NO_KEY, NO_KEY, NO_KEY), 1,
            120, 40, 560, 460, BOMB_ARMED, 20, 40, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0010));
        steps.push_back(make_step(pack_keys(NO_KEY, NO_KEY, NO_KEY, NO_KEY), 3,
            120, 40, 560, 460, BOMB_EXPLODING, 20, 40, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0000));
        steps.push_back(make_step(pack_keys(NO_KEY, NO_KEY, NO_KEY, NO_KEY), 4,
            120, 40, 560, 460, BOMB_IDLE, 20, 40, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0000));
        // Bring player 2 to four tiles right of player 1
        steps.push_back(make_step(pack_keys(KEY_LEFT, NO_KEY, NO_KEY, NO_KEY), 18,
            120, 40, 200, 460, BOMB_IDLE, 20, 40, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0000));
        steps.push_back(make_step(pack_keys(KEY_UP, NO_KEY, NO_KEY, NO_KEY), 21,
            120, 40, 200, 40, BOMB_IDLE, 20, 40, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0000));
        // Second bomb hits player 2 at the arm tip
        steps.push_back(make_step(pack_keys(KEY_SPACE, NO_KEY, NO_KEY, NO_KEY), 0,
            120, 40, 200, 40, BOMB_ARMED, 120, 40, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b0000));
        steps.push_back(make_step(pack_keys(KEY_S, NO_KEY, NO_KEY, NO_KEY), 5,
            120, 140, 200, 40, BOMB_ARMED, 120, 40, ROUND_PLAY, 2'b00, TUNE_MAIN, 4'b1000));
        steps.push_back(make_step(pack_keys(NO_KEY, NO_KEY, NO_KEY, NO_KEY), 3,
            120, 140, 200, 40, BOMB_EXPLODING, 120, 40, ROUND_OVER, 2'b10, TUNE_DEFEAT,
            4'b0000));
        // Frozen round
        steps.push_back(make_step(pack_keys(KEY_D, KEY_DOWN, NO_KEY, NO_KEY), 3,
            120, 140, 200, 40, BOMB_EXPLODING, 120, 40, ROUND_OVER, 2'b10, TUNE_DEFEAT,
            4'b0010));
        steps.push_back(make_step(pack_keys(KEY_SPACE, KEY_ENTER, NO_KEY, NO_KEY), 2,
            120, 140, 200, 40, BOMB_IDLE, 120, 40, ROUND_OVER, 2'b10, TUNE_DEFEAT, 4'b0000));
    endtask

    //--------------------------------------
    // Main sequence
    //--------------------------------------
    initial
    begin
        step_t s;
        void'($urandom(32'h56e1));
        rst_n      = 1'b0;
        frame_tick = 1'b0;
        key_report = '0;
        load_steps();

        repeat (5) @(posedge Clk);
        rst_n <= 1'b1;

        foreach (steps[i])
        begin
            s = steps[i];
            @(posedge Clk);
            key_report <= s.keys;
            pulse_frame_ticks(int'(s.ticks));
            repeat (2) @(posedge Clk); // Registered outputs settle
            @(negedge Clk);
            if (s.defeated != 2'b00)
                wait_for_defeat(s.defeated);

            compare_value($sformatf("step %0d p1_pos", i), 32'(p1_pos), 32'(s.p1_pos));
            compare_value($sformatf("step %0d p2_pos", i), 32'(p2_pos), 32'(s.p2_pos));
            compare_value($sformatf("step %0d p1_bomb", i), 32'(p1_bomb), 32'(s.p1_bomb));
            compare_value($sformatf("step %0d p2_bomb", i), 32'(p2_bomb), 32'(IDLE_BOMB));
            compare_value($sformatf("step %0d defeated", i), 32'(defeated),
                          32'(s.defeated));
            compare_value($sformatf("step %0d round_state", i), 32'(round_state),
                          32'(s.round_state));
            compare_value($sformatf("step %0d tune", i), 32'(tune), 32'(s.tune));
            compare_value($sformatf("step %0d led", i), 32'(led), 32'(s.led));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

/* bomber_top.f */
hdl/bomber_pkg.sv
hdl/key_decoder.sv
hdl/player_motion.sv
hdl/bomb_timer.sv
hdl/blast_checker.sv
hdl/game_ctrl.sv
hdl/bomber_top.sv
dv/tb_clock_gen.sv
dv/tb_bomber_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bomber_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_bomber_top -f bomber_top.f --Mdir obj_dir

output="$(./obj_dir/Vtb_bomber_top 2>&1 || true)"
echo "$output"

if grep -qx "TEST PASS" <<< "$output"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi
